// ==== common/eth_frame_pkg.sv ====
package eth_frame_pkg;

    ////////////////////
    // Octets and CRC
    ////////////////////

    typedef logic [7:0]  byte_t;                    // One octet of frame data
    typedef logic [31:0] crc_t;                     // Running CRC-32 state

    parameter crc_t crc_init = 32'hffff_ffff;       // The CRC register starts from all ones

    ////////////////////
    // Framing constants
    ////////////////////

    parameter byte_t preamble_byte = 8'h55;         // Alternating ones and zeros for clock recovery
    parameter byte_t sfd_byte      = 8'hd5;         // Start frame delimiter
    parameter byte_t pad_byte      = 8'h00;         // Filler for short payloads

    parameter int preamble_len  = 7;                // Preamble bytes ahead of the SFD
    parameter int min_frame_len = 60;               // Address, type and payload, FCS excluded
    parameter int fcs_len       = 4;                // Frame check sequence bytes

    // Framer states in the order a frame walks through them
    typedef enum logic [2:0] {
        st_idle,                                    // Waiting for the FIFO to offer a frame
        st_preamble,                                // Sending the 0x55 bytes
        st_sfd,                                     // Sending the delimiter
        st_payload,                                 // Forwarding FIFO bytes with header fields merged
        st_pad,                                     // Filling up to the minimum frame length
        st_fcs,                                     // Sending the complemented CRC, low byte first
        st_gap                                      // Holding the line idle for 96 bit times
    } framer_state_t;

endpackage

// ==== common/net_hdr_pkg.sv ====
package net_hdr_pkg;

    typedef logic [15:0] hdr_word_t;                // One 16-bit IPv4 or UDP header field
    typedef logic [10:0] offset_t;                  // Payload byte offset from the first destination byte
    typedef logic [10:0] gap_t;                     // Inter-frame gap counter

    // Fields that the MAC fills in late, in the order of the inserter array
    typedef enum logic [1:0] {
        fld_ip_length,
        fld_ip_checksum,
        fld_udp_length,
        fld_udp_checksum
    } field_idx_t;

    // First byte of each field, counted from the destination address
    // 14 bytes of Ethernet header, then IPv4 total length at +2 and checksum at +10
    // The UDP header follows a 20-byte IPv4 header, length at +4 and checksum at +6
    parameter offset_t field_offset [0:3] = '{11'd16, 11'd24, 11'd38, 11'd40};

    typedef enum logic [1:0] {
        speed_10m,
        speed_100m,
        speed_1g
    } link_speed_t;

    // 96 bit times in 125 MHz clock cycles, indexed by link_speed_t
    // The unused fourth code falls back to the gigabit gap
    parameter gap_t gap_cycles [0:3] = '{11'd1200, 11'd120, 11'd12, 11'd12};

endpackage

// ==== src/crc32_fcs.sv ====
`timescale 1ns/1ps

module crc32_fcs
    import eth_frame_pkg::*;
(
    input  logic  clk,
    input  logic  reset_n,
    input  logic  frame_start,                   // Reloads the seed for a new frame
    input  logic  crc_advance,                   // Fold tx_byte in on this clock
    input  byte_t tx_byte,
    output crc_t  fcs_value
);

    // IEEE 802.3 polynomial, bit reversed for LSB-first processing
    localparam crc_t crc_poly = 32'hedb8_8320;

    crc_t crc_state;

    // One byte through the reflected CRC, a bit at a time
    function automatic crc_t crc_byte(input crc_t crc, input byte_t data);
        crc_t c;
        int   b;
        c = crc ^ {24'd0, data};
        for (b = 0; b < 8; b++) begin
            if (c[0]) begin
                c = (c >> 1) ^ crc_poly;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    always_ff @(posedge clk) begin
        if (reset_n) begin
            crc_state <= crc_init;
        end else if (frame_start) begin
            crc_state <= crc_init;
        end else if (crc_advance) begin
            crc_state <= crc_byte(crc_state, tx_byte);
        end
    end

    // The wire carries the one's complement
    assign fcs_value = ~crc_state;

endmodule

// ==== tx_mac/hdr_latch.sv ====
`timescale 1ns/1ps

module hdr_latch
    import net_hdr_pkg::*;
(
    input  logic            clk,
    input  logic            reset_n,
    input  logic            frame_start,         // Clears the offset for a new frame
    input  logic            in_preamble,         // Sampling window, already qualified by PHY ready
    input  logic            byte_take,           // One payload byte accepted
    input  logic            hdr_valid,
    input  hdr_word_t       ip_length,
    input  hdr_word_t       ip_checksum,
    input  hdr_word_t       udp_length,
    input  hdr_word_t       udp_checksum,
    output hdr_word_t [3:0] latched_fields,
    output offset_t         payload_offset
);

    // Counting stops just past the last byte of the last field
    localparam offset_t offset_limit = field_offset[fld_udp_checksum] + offset_t'(2);

    // Header words, any valid sample in the preamble overwrites the previous one
    always_ff @(posedge clk) begin
        if (in_preamble && hdr_valid) begin
            latched_fields[fld_ip_length]    <= ip_length;
            latched_fields[fld_ip_checksum]  <= ip_checksum;
            latched_fields[fld_udp_length]   <= udp_length;
            latched_fields[fld_udp_checksum] <= udp_checksum;
        end
    end

    // Offset of the payload byte on offer right now
    always_ff @(posedge clk) begin
        if (reset_n) begin
            payload_offset <= '0;
        end else if (frame_start) begin
            payload_offset <= '0;
        end else if (byte_take && (payload_offset < offset_limit)) begin
            payload_offset <= payload_offset + 1'b1;
        end
    end

endmodule

// ==== tx_mac/hdr_field_insert.sv ====
`timescale 1ns/1ps

module hdr_field_insert
    import eth_frame_pkg::*, net_hdr_pkg::*;
#(
    parameter offset_t first_offset = '0,        // Offset of the field's high byte
    parameter bit      enable       = 1'b1       // Cleared when the stack fills this field itself
) (
    input  offset_t   payload_offset,
    input  hdr_word_t field_word,
    output logic      field_hit,
    output byte_t     field_byte
);

    logic hit_high;
    logic hit_low;

    // Network order puts the high byte first
    assign hit_high = enable && (payload_offset == first_offset);
    assign hit_low  = enable && (payload_offset == first_offset + offset_t'(1));

    assign field_hit  = hit_high || hit_low;
    assign field_byte = hit_high ? field_word[15:8] : field_word[7:0];

endmodule

// ==== tx_mac/byte_merge.sv ====
`timescale 1ns/1ps

module byte_merge
    import eth_frame_pkg::*;
(
    input  byte_t       s_tx_axis_tdata,
    input  logic        pad_active,              // Framer is padding, the FIFO byte is not ours
    input  logic [3:0]  field_hit,
    input  byte_t [3:0] field_byte,
    output byte_t       tx_byte
);

    byte_t hit_byte;

    // Field offsets never overlap, so OR-ing the masked bytes is a one-hot select
    always_comb begin
        hit_byte = '0;
        for (int i = 0; i < 4; i++) begin
            hit_byte = hit_byte | (field_byte[i] & {8{field_hit[i]}});
        end
    end

    always_comb begin
        if (pad_active) begin
            tx_byte = pad_byte;                  // Padding reaches the CRC through here too
        end else if (|field_hit) begin
            tx_byte = hit_byte;
        end else begin
            tx_byte = s_tx_axis_tdata;
        end
    end

endmodule

// ==== tx_mac/tx_framer.sv ====
`timescale 1ns/1ps

module tx_framer
    import eth_frame_pkg::*, net_hdr_pkg::*;
#(
    parameter int min_frame_len = eth_frame_pkg::min_frame_len
) (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        s_tx_axis_tvalid,
    input  logic        s_tx_axis_tlast,
    input  logic        rx_pause,
    input  logic        phy_tx_ready,
    input  link_speed_t link_speed,
    input  byte_t       tx_byte,                     // Merged payload byte, or the pad byte while padding
    input  crc_t        fcs_value,                   // Complemented CRC, ready to send
    output logic        s_tx_axis_tready,
    output byte_t       phy_tx_data,
    output logic        phy_tx_dv,
    output logic        frame_start,
    output logic        in_preamble,
    output logic        byte_take,
    output logic        pad_active,
    output logic        crc_advance
);

    framer_state_t state;
    logic [2:0]    pre_cnt;                          // Preamble bytes already loaded
    offset_t       frame_cnt;                        // Bytes after the SFD, held once the minimum is met
    logic [1:0]    fcs_cnt;                          // Which FCS byte goes out next
    gap_t          gap_cnt;                          // Idle cycles still owed
    logic          frame_full;

    ////////////////////
    // Strobes
    ////////////////////

    // A frame may start only when the FIFO has data, no pause is pending and the PHY takes bytes
    assign frame_start = (state == st_idle) && s_tx_axis_tvalid && !rx_pause && phy_tx_ready;

    // Header sampling window, frozen along with everything else
    assign in_preamble = ((state == st_preamble) || (state == st_sfd)) && phy_tx_ready;

    assign s_tx_axis_tready = (state == st_payload) && phy_tx_ready;
    assign byte_take        = s_tx_axis_tready && s_tx_axis_tvalid;
    assign pad_active       = (state == st_pad); // Steers the merger to the pad byte

    // The CRC sees every payload and pad byte exactly once
    assign crc_advance = byte_take || (pad_active && phy_tx_ready);

    // The byte going out now is at least the last one of the minimum frame
    assign frame_full = (frame_cnt >= offset_t'(min_frame_len - 1));

    ////////////////////
    // Frame FSM
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset_n) begin
            state     <= st_idle;
            phy_tx_dv <= 1'b0;
            pre_cnt   <= '0;
            frame_cnt <= '0;
            fcs_cnt   <= '0;
            gap_cnt   <= '0;
        end else if (phy_tx_ready) begin             // A stalled PHY holds every register
            case (state)
                st_idle: begin
                    phy_tx_dv <= 1'b0;
                    if (frame_start) begin
                        // First preamble byte loads right away so dv rises on the next cycle
                        phy_tx_data <= preamble_byte;
                        phy_tx_dv   <= 1'b1;
                        pre_cnt     <= 3'd1;
                        state       <= st_preamble;
                    end
                end
                st_preamble: begin
                    phy_tx_data <= preamble_byte;
                    pre_cnt     <= pre_cnt + 1'b1;
                    if (pre_cnt == 3'(preamble_len - 1)) begin
                        state <= st_sfd;             // That was the seventh
                    end
                end
                st_sfd: begin
                    phy_tx_data <= sfd_byte;
                    frame_cnt   <= '0;
                    state       <= st_payload;
                end
                st_payload: begin
                    // The FIFO keeps tvalid up through tlast, so a gap here only waits
                    if (byte_take) begin
                        phy_tx_data <= tx_byte;
                        if (!frame_full) begin
                            frame_cnt <= frame_cnt + 1'b1;
                        end
                        if (s_tx_axis_tlast) begin
                            fcs_cnt <= '0;
                            state   <= frame_full ? st_fcs : st_pad; // Short frames get padded
                        end
                    end
                end
                st_pad: begin
                    phy_tx_data <= tx_byte;
                    frame_cnt   <= frame_cnt + 1'b1;
                    if (frame_full) begin
                        fcs_cnt <= '0;
                        state   <= st_fcs;
                    end
                end
                st_fcs: begin
                    // CRC already holds the last data byte, sent least significant byte first
                    phy_tx_data <= fcs_value[{fcs_cnt, 3'b000} +: 8];
                    fcs_cnt     <= fcs_cnt + 1'b1;
                    if (fcs_cnt == 2'(fcs_len - 1)) begin
                        gap_cnt <= gap_cycles[link_speed]; // Gap length follows the current speed
                        state   <= st_gap;
                    end
                end
                st_gap: begin
                    phy_tx_dv <= 1'b0;
                    if (gap_cnt == '0) begin
                        state <= st_idle;
                    end else begin
                        gap_cnt <= gap_cnt - 1'b1;
                    end
                end
                default: begin
                    state     <= st_idle;        // Unused encoding recovers to idle
                    phy_tx_dv <= 1'b0;
                end
            endcase
        end
    end

endmodule

// ==== tx_mac/tx_mac_top.sv ====
`timescale 1ns/1ps

module tx_mac_top
    import eth_frame_pkg::*, net_hdr_pkg::*;
#(
    parameter bit udp_insert    = 1'b1,                      // Fill in UDP length and checksum
    parameter bit ip_insert     = 1'b1,                      // Fill in IPv4 length and checksum
    parameter int min_frame_len = eth_frame_pkg::min_frame_len
) (
    input  logic        clk,
    input  logic        reset_n,

    // FIFO side, one byte per accepted beat
    input  byte_t       s_tx_axis_tdata,
    input  logic        s_tx_axis_tvalid,
    input  logic        s_tx_axis_tlast,
    output logic        s_tx_axis_tready,

    // PHY side
    input  logic        phy_tx_ready,
    output byte_t       phy_tx_data,
    output logic        phy_tx_dv,

    input  logic        rx_pause,                            // Peer asked us to hold off

    // Late-computed header values
    input  logic        hdr_valid,
    input  hdr_word_t   ip_length,
    input  hdr_word_t   ip_checksum,
    input  hdr_word_t   udp_length,
    input  hdr_word_t   udp_checksum,

    input  link_speed_t link_speed
);

    logic              frame_start;
    logic              in_preamble;
    logic              byte_take;
    logic              pad_active;
    logic              crc_advance;
    hdr_word_t [3:0]   latched_fields;
    offset_t           payload_offset;
    logic [3:0]        field_hit;
    byte_t [3:0]       field_byte;
    byte_t             tx_byte;                              // Byte headed for the wire and the CRC
    crc_t              fcs_value;

    hdr_latch u_latch (
        .clk            (clk),
        .reset_n        (reset_n),
        .frame_start    (frame_start),
        .in_preamble    (in_preamble),
        .byte_take      (byte_take),
        .hdr_valid      (hdr_valid),
        .ip_length      (ip_length),
        .ip_checksum    (ip_checksum),
        .udp_length     (udp_length),
        .udp_checksum   (udp_checksum),
        .latched_fields (latched_fields),
        .payload_offset (payload_offset)
    );

    ////////////////////
    // Field inserters
    ////////////////////

    for (genvar i = 0; i < 4; i++) begin : g_insert
        localparam field_idx_t idx = field_idx_t'(i);
        localparam bit is_udp = (idx == fld_udp_length) || (idx == fld_udp_checksum);

        hdr_field_insert #(
            .first_offset (field_offset[i]),
            .enable       (is_udp ? udp_insert : ip_insert)  // Pairs share one enable
        ) u_insert (
            .payload_offset (payload_offset),
            .field_word     (latched_fields[i]),
            .field_hit      (field_hit[i]),
            .field_byte     (field_byte[i])
        );
    end

    byte_merge u_merge (
        .s_tx_axis_tdata (s_tx_axis_tdata),
        .pad_active      (pad_active),
        .field_hit       (field_hit),
        .field_byte      (field_byte),
        .tx_byte         (tx_byte)
    );

    crc32_fcs u_crc (
        .clk         (clk),
        .reset_n     (reset_n),
        .frame_start (frame_start),
        .crc_advance (crc_advance),
        .tx_byte     (tx_byte),
        .fcs_value   (fcs_value)
    );

    tx_framer #(
        .min_frame_len (min_frame_len)
    ) u_framer (
        .clk              (clk),
        .reset_n          (reset_n),
        .s_tx_axis_tvalid (s_tx_axis_tvalid),
        .s_tx_axis_tlast  (s_tx_axis_tlast),
        .rx_pause         (rx_pause),
        .phy_tx_ready     (phy_tx_ready),
        .link_speed       (link_speed),
        .tx_byte          (tx_byte),
        .fcs_value        (fcs_value),
        .s_tx_axis_tready (s_tx_axis_tready),
        .phy_tx_data      (phy_tx_data),
        .phy_tx_dv        (phy_tx_dv),
        .frame_start      (frame_start),
        .in_preamble      (in_preamble),
        .byte_take        (byte_take),
        .pad_active       (pad_active),
        .crc_advance      (crc_advance)
    );

endmodule

// ==== tests/tb_frame_model.svh ====
`ifndef TB_FRAME_MODEL_SVH
`define TB_FRAME_MODEL_SVH

// Standard IPv4 and UDP field positions from the first destination byte
localparam int ref_field_pos [0:3] = '{16, 24, 38, 40};

// Ethernet CRC-32, LSB-first, one data bit per step
function automatic logic [31:0] ref_crc_byte(input logic [31:0] crc, input byte_t data);
    logic [31:0] c;
    logic        fb;
    c = crc;
    for (int k = 0; k < 8; k++) begin
        fb = c[0] ^ data[k];                       // Feedback bit of the shift register
        c  = {1'b0, c[31:1]};
        if (fb) c = c ^ 32'hedb8_8320;
    end
    return c;
endfunction

// Fills exp_q from payload_q and hdr_words
task automatic build_expected();
    byte_t       body [$];
    logic [31:0] crc;
    byte_t       b;
    exp_q.delete();
    for (int i = 0; i < 7; i++) exp_q.push_back(8'h55);
    exp_q.push_back(8'hd5);
    for (int i = 0; i < payload_q.size(); i++) begin
        b = payload_q[i];
        for (int f = 0; f < 4; f++) begin
            if (i == ref_field_pos[f]) b = hdr_words[f][15:8];     // High byte first
            if (i == ref_field_pos[f] + 1) b = hdr_words[f][7:0];
        end
        body.push_back(b);
    end
    while (body.size() < 60) body.push_back(8'h00); // Zero padding
    crc = 32'hffff_ffff;
    foreach (body[i]) begin
        crc = ref_crc_byte(crc, body[i]);
        exp_q.push_back(body[i]);
    end
    crc = ~crc;
    for (int i = 0; i < 4; i++) exp_q.push_back(crc[8*i +: 8]);
endtask

task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
    if (expected !== actual) begin
        $display("Fail %s: expected %02h, actual %02h", name, expected, actual);
        test_errors++;
    end
endtask

task automatic check_gap(input string name, input gap_t min_gap, input gap_t actual);
    if (actual < min_gap) begin
        $display("Fail %s: expected at least %0d, actual %0d", name, min_gap, actual);
        test_errors++;
    end
endtask

`endif

// ==== tests/tb_tx_mac.sv ====
`timescale 1ns/1ps

module tb_tx_mac
    import eth_frame_pkg::*, net_hdr_pkg::*;
;
    logic clk, reset_n;
    byte_t s_tx_axis_tdata;
    logic s_tx_axis_tvalid, s_tx_axis_tlast, s_tx_axis_tready;
    logic phy_tx_ready, phy_tx_dv, rx_pause, hdr_valid;
    byte_t phy_tx_data;
    hdr_word_t ip_length, ip_checksum, udp_length, udp_checksum;
    link_speed_t link_speed;

    byte_t payload_q [$];
    byte_t exp_q [$];
    byte_t cap_q [$];
    byte_t saved_q [$];                          // Payload of the long frame
    hdr_word_t hdr_words [0:3];
    int unsigned lcg_state = 92;
    int test_errors, tests_ok, tests_bad;
    logic capture_on, stall_on, ready_prev, dv_prev;
    int idle_run, last_gap;

    `include "tb_frame_model.svh"

    tx_mac_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    // PHY ready drops at random cycles while stall_on is set
    initial begin
        int unsigned r;
        phy_tx_ready = 1'b1;
        forever begin
            @(posedge clk);
            #2;
            r = lcg_next();
            phy_tx_ready = stall_on ? ((r % 4) != 0) : 1'b1;
        end
    end

    ////////////////////
    // Capture and gap monitor sampled mid-cycle
    ////////////////////
    initial begin
        ready_prev = 1'b0;
        dv_prev = 1'b0;
        idle_run = 0;
        last_gap = 0;
        forever begin
            @(negedge clk);
            if (capture_on && ready_prev && phy_tx_dv) cap_q.push_back(phy_tx_data); // New byte
            // The FIFO may only be drained inside a frame while the PHY takes bytes
            if (s_tx_axis_tready && !(phy_tx_ready && phy_tx_dv)) begin
                $display("FIFO ready was high outside a payload cycle with the PHY ready");
                test_errors++;
            end
            if (phy_tx_dv) begin
                if (!dv_prev) last_gap = idle_run;
                idle_run = 0;
            end else begin
                idle_run++;
            end
            dv_prev = phy_tx_dv;
            ready_prev = phy_tx_ready;           // Decides whether the next edge loads a byte
        end
    end

    // Inputs change a fixed 2 ns after the rising edge
    task automatic wait_drive_slot();
        @(posedge clk);
        #2;
    endtask

    task automatic make_payload(input int n);
        int unsigned r;
        payload_q.delete();
        for (int i = 0; i < n; i++) begin
            r = lcg_next();
            payload_q.push_back(r[7:0]);
        end
    endtask

    task automatic set_words(input hdr_word_t a, input hdr_word_t b, input hdr_word_t c,
                             input hdr_word_t d);
        hdr_words[0] = a;
        hdr_words[1] = b;
        hdr_words[2] = c;
        hdr_words[3] = d;
        ip_length = a;
        ip_checksum = b;
        udp_length = c;
        udp_checksum = d;
    endtask

    // Drives payload_q through the FIFO port and pulses hdr_valid during the preamble
    task automatic send_frame();
        int t;
        cap_q.delete();
        capture_on = 1'b1;
        s_tx_axis_tdata = payload_q[0];
        s_tx_axis_tlast = (payload_q.size() == 1);
        s_tx_axis_tvalid = 1'b1;
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (!phy_tx_dv && t < 3000);
        if (!phy_tx_dv) begin
            $display("Frame never started on the PHY side");
            test_errors++;
        end
        @(posedge clk);
        #2 hdr_valid = 1'b1;
        for (int i = 0; i < payload_q.size(); i++) begin
            s_tx_axis_tdata = payload_q[i];
            s_tx_axis_tlast = (i == payload_q.size() - 1);
            t = 0;
            do begin
                @(negedge clk);
                t++;
            end while (!s_tx_axis_tready && t < 300);
            if (!s_tx_axis_tready) begin
                $display("FIFO byte %0d was never accepted", i);
                test_errors++;
                break;
            end
            @(posedge clk);
            #2 hdr_valid = 1'b0;
        end
        s_tx_axis_tvalid = 1'b0;
        s_tx_axis_tlast = 1'b0;
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (phy_tx_dv && t < 3000);
        if (phy_tx_dv) begin
            $display("Frame never ended on the PHY side");
            test_errors++;
        end
        capture_on = 1'b0;
    endtask

    task automatic check_frame(input string name);
        build_expected();
        if (cap_q.size() != exp_q.size()) begin
            $display("Fail %s: frame length expected %0d, actual %0d", name, exp_q.size(),
                     cap_q.size());
            test_errors++;
        end else begin
            foreach (exp_q[i]) check_byte(name, exp_q[i], cap_q[i]);
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            $display("%s: ok", name);
            tests_ok++;
        end else begin
            $display("%s: %0d errors", name, test_errors);
            tests_bad++;
        end
        test_errors = 0;
    endtask

    ////////////////////
    // Directed tests
    ////////////////////
    task automatic short_frame_test();
        wait_drive_slot();
        make_payload(20);
        set_words(16'h0030, 16'h1111, 16'h001c, 16'h2222);
        send_frame();
        check_frame("short_frame_pad");
        finish_test("short_frame_pad");
    endtask

    task automatic long_frame_test();
        wait_drive_slot();
        make_payload(100);
        saved_q = payload_q;
        set_words(16'h0056, 16'habcd, 16'h0042, 16'h5a5a);
        send_frame();
        check_frame("long_frame");
        finish_test("long_frame");
    endtask

    task automatic header_insert_test();
        wait_drive_slot();
        make_payload(64);
        set_words(16'h1234, 16'h5678, 16'h9abc, 16'hdef0);
        send_frame();
        check_frame("header_insert");
        if (cap_q.size() >= 50) begin
            for (int f = 0; f < 4; f++) begin
                check_byte("header_insert", hdr_words[f][15:8], cap_q[8 + ref_field_pos[f]]);
                check_byte("header_insert", hdr_words[f][7:0], cap_q[9 + ref_field_pos[f]]);
            end
        end
        finish_test("header_insert");
    endtask

    // Same payload and words as the long frame while the PHY stalls
    task automatic phy_stall_test();
        wait_drive_slot();
        payload_q = saved_q;
        set_words(16'h0056, 16'habcd, 16'h0042, 16'h5a5a);
        stall_on = 1'b1;
        send_frame();
        stall_on = 1'b0;
        check_frame("phy_stall");
        finish_test("phy_stall");
    endtask

    task automatic rx_pause_test();
        wait_drive_slot();
        make_payload(30);
        rx_pause = 1'b1;
        s_tx_axis_tdata = payload_q[0];
        s_tx_axis_tvalid = 1'b1;
        for (int i = 0; i < 40; i++) begin
            @(negedge clk);
            if (phy_tx_dv) begin
                $display("Frame started while rx_pause was high");
                test_errors++;
                break;
            end
        end
        @(posedge clk);
        #2 rx_pause = 1'b0;
        send_frame();
        check_frame("rx_pause_holdoff");
        finish_test("rx_pause_holdoff");
    endtask

    task automatic gap_test(input link_speed_t speed, input gap_t min_gap, input string name);
        wait_drive_slot();
        link_speed = speed;
        make_payload(20);
        send_frame();
        wait_drive_slot();
        make_payload(20);
        send_frame();                            // Offered while the first frame's gap runs
        check_frame(name);
        check_gap(name, min_gap, gap_t'(last_gap));
        finish_test(name);
    endtask

    initial begin
        reset_n = 1'b1;
        s_tx_axis_tdata = '0;
        s_tx_axis_tvalid = 1'b0;
        s_tx_axis_tlast = 1'b0;
        rx_pause = 1'b0;
        hdr_valid = 1'b0;
        link_speed = speed_1g;
        capture_on = 1'b0;
        stall_on = 1'b0;
        test_errors = 0;
        tests_ok = 0;
        tests_bad = 0;
        set_words('0, '0, '0, '0);
        repeat (3) @(posedge clk);
        #2 reset_n = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        short_frame_test();
        long_frame_test();
        header_insert_test();
        phy_stall_test();
        rx_pause_test();
        gap_test(speed_10m, 11'd1200, "gap_10m");
        gap_test(speed_100m, 11'd120, "gap_100m");
        gap_test(speed_1g, 11'd12, "gap_1g");
        $display("Tests passed: %0d, tests failed: %0d", tests_ok, tests_bad);
        if (tests_bad == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
common/eth_frame_pkg.sv
common/net_hdr_pkg.sv
src/crc32_fcs.sv
tx_mac/hdr_latch.sv
tx_mac/hdr_field_insert.sv
tx_mac/byte_merge.sv
tx_mac/tx_framer.sv
tx_mac/tx_mac_top.sv
+incdir+tests
tests/tb_tx_mac.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FLAGS      ?= --timing -Wno-fatal
TOP        ?= tb_tx_mac
FLIST      ?= flist.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

$(OBJ_DIR)/V$(TOP): $(FLIST)
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG) || { echo "Simulation did not pass"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
